// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_l2_cache
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed

SRCS := $(wildcard hw/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/mem_model.sv ====
/*
 * wishbone classic slave memory, one whole line per transfer
 * random ack delay per transfer
 * sparse storage, untouched lines read back an address pattern
 */
`timescale 1ns/1ns

module mem_model
    import cache_pkg::*;
#(
    parameter int MAX_DELAY = 5
) (
    input  logic    clk,
    input  logic    arst_n_i,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o
);

    localparam int WORDS = $bits(line_t) / 32;

    line_t   mem_q [addr_t];
    wb_rsp_t rsp_q = '0;
    int      delay_left = -1;
    logic    ack_next;
    line_t   dat_next;
    addr_t   line_adr;

    // power-up contents derived from every address bit
    function automatic line_t fill_line(input addr_t adr);
        line_t pattern;
        for (int i = 0; i < WORDS; i++) begin
            pattern[32*i +: 32] = (adr + 32'(4 * i)) * 32'h9e37_79b1;
        end
        return pattern;
    endfunction

    // request sampled at the edge and response driven 2 ns later
    always @(posedge clk) begin
        ack_next = 1'b0;
        dat_next = rsp_q.dat;
        line_adr = {req_i.adr[31:OFFSET_W], {OFFSET_W{1'b0}}};
        if (!arst_n_i || !(req_i.cyc && req_i.stb) || rsp_q.ack) begin
            delay_left = -1;
        end else begin
            if (delay_left < 0) begin
                delay_left = $urandom_range(MAX_DELAY, 0);
            end
            if (delay_left == 0) begin
                ack_next   = 1'b1;
                delay_left = -1;
                if (req_i.we) begin
                    mem_q[line_adr] = req_i.dat;
                end else if (mem_q.exists(line_adr)) begin
                    dat_next = mem_q[line_adr];
                end else begin
                    dat_next = fill_line(line_adr);
                end
            end else begin
                delay_left--;
            end
        end
        #2;
        rsp_q = '{ack: ack_next, dat: dat_next};
    end

    assign rsp_o = rsp_q;

endmodule

// ==== bench/tb_l2_cache.sv ====
/*
 * testbench for the L2 cache
 * clock, reset and CPU side Wishbone stimulus
 * shadow memory with reference merge function
 * read comparing process and memory port monitor
 */
`timescale 1ns/1ns

module tb_l2_cache
    import cache_pkg::*;
();

    localparam int ACK_LIMIT = 400;
    localparam int RAND_OPS  = 300;
    localparam int WORDS     = $bits(line_t) / 32;

    logic    clk = 1'b0;
    logic    arst_n;
    wb_req_t cpu_req;
    wb_rsp_t cpu_rsp;
    wb_req_t mem_req;
    wb_rsp_t mem_rsp;

    line_t   shadow [addr_t];
    line_t   exp_rdata;
    int      checks = 0;
    int      errors = 0;
    int      read_checks = 0;
    int      read_errors = 0;
    int      mem_cycles = 0;
    int      mem_writes = 0;
    addr_t   last_wb_adr;
    line_t   last_wb_dat;

    l2_cache i_l2_cache (
        .clk       (clk),
        .arst_n_i  (arst_n),
        .cpu_req_i (cpu_req),
        .cpu_rsp_o (cpu_rsp),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    mem_model #(
        .MAX_DELAY(5)
    ) i_mem_model (
        .clk      (clk),
        .arst_n_i (arst_n),
        .req_i    (mem_req),
        .rsp_o    (mem_rsp)
    );

    always #20 clk = ~clk;

    // memory contents before any write-back
    function automatic line_t initial_line(input addr_t adr);
        line_t pattern;
        for (int i = 0; i < WORDS; i++) begin
            pattern[32*i +: 32] = (adr + 32'(4 * i)) * 32'h9e37_79b1;
        end
        return pattern;
    endfunction

    function automatic line_t shadow_line(input addr_t adr);
        if (shadow.exists(adr)) begin
            return shadow[adr];
        end
        return initial_line(adr);
    endfunction

    // bytes with sel set come from the write data and the rest stay
    function automatic line_t expected_line(input line_t old, input line_t wdat, input be_t sel);
        line_t merged;
        merged = old;
        for (int b = 0; b < $bits(be_t); b++) begin
            if (sel[b]) begin
                merged[8*b +: 8] = wdat[8*b +: 8];
            end
        end
        return merged;
    endfunction

    function automatic line_t random_line();
        line_t rnd;
        for (int i = 0; i < WORDS; i++) begin
            rnd[32*i +: 32] = $urandom;
        end
        return rnd;
    endfunction

    function automatic addr_t line_addr(input int tag, input int idx);
        return (addr_t'(tag) << (OFFSET_W + INDEX_W)) | (addr_t'(idx) << OFFSET_W);
    endfunction

    function automatic int total_errors();
        return errors + read_errors;
    endfunction

    task automatic check_value(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("MISMATCH at %0t ns: %s", $time, what);
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        if (total_errors() == err_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, total_errors() - err_start);
        end
    endtask

    // one transfer with cycles counting rising edges from request to visible ack
    task automatic cpu_access(input logic we, input addr_t adr, input be_t sel,
                              input line_t dat, output int cycles);
        logic acked;
        int   n;
        acked = 1'b0;
        n     = 0;
        if (we) begin
            shadow[adr] = expected_line(shadow_line(adr), dat, sel);
        end else begin
            exp_rdata = shadow_line(adr);
        end
        cpu_req = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
        while (!acked && n < ACK_LIMIT) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            acked = cpu_rsp.ack;
        end
        cycles = n;
        @(posedge clk);
        #2;
        cpu_req = '0;
        if (!acked) begin
            $display("timeout: no CPU ack for access to %h after %0d cycles", adr, n);
            $display("Testbench failed");
            $finish;
        end
    endtask

    // memory port activity and byte select
    always @(negedge clk) begin
        if (mem_req.cyc) begin
            mem_cycles++;
        end
        if (mem_req.cyc && mem_req.stb) begin
            check_value(mem_req.sel == '1,
                        $sformatf("memory byte select %h, expected all set", mem_req.sel));
        end
        if (mem_req.cyc && mem_req.stb && mem_req.we && mem_rsp.ack) begin
            mem_writes++;
            last_wb_adr = mem_req.adr;
            last_wb_dat = mem_req.dat;
        end
    end

    // every CPU read response against the shadow memory
    always @(negedge clk) begin
        if (cpu_rsp.ack && cpu_req.cyc && !cpu_req.we) begin
            read_checks++;
            assert (cpu_rsp.dat == exp_rdata) else begin
                read_errors++;
                $display("MISMATCH at %0t ns: read of %h returned %h, expected %h",
                         $time, cpu_req.adr, cpu_rsp.dat, exp_rdata);
            end
        end
    end

    initial begin
        addr_t a_first;
        addr_t a_mru;
        line_t wdat;
        be_t   wsel;
        int    err_start;
        int    cyc_start;
        int    wr_start;
        int    lat;
        int    op_tag;
        int    op_idx;

        void'($urandom(32'ha3da));
        arst_n  = 1'b0;
        cpu_req = '0;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // quiet ports before a cold miss
        err_start = total_errors();
        repeat (5) begin
            @(negedge clk);
            check_value(!cpu_rsp.ack && !mem_req.cyc, "ack or memory cyc high with no request");
        end
        @(posedge clk);
        #2;
        a_first = line_addr(32'h123, 0);
        cpu_access(1'b0, a_first, '1, '0, lat);
        check_value(lat > 2, $sformatf("first read took %0d cycles, expected a miss", lat));
        finish_test("1 reset and cold read", err_start);

        err_start = total_errors();
        cyc_start = mem_cycles;
        cpu_access(1'b0, a_first, '1, '0, lat);
        check_value(lat == 2, $sformatf("hit latency %0d, expected 2", lat));
        check_value(mem_cycles == cyc_start, "memory port active during a read hit");
        finish_test("2 read hit", err_start);

        err_start = total_errors();
        wr_start  = mem_writes;
        wdat      = random_line();
        wsel      = $urandom;
        cpu_access(1'b1, a_first, wsel, wdat, lat);
        cpu_access(1'b0, a_first, '1, '0, lat);
        check_value(mem_writes == wr_start, "memory written after a write hit");
        finish_test("3 partial write", err_start);

        // dirty line in the oldest way of set 2
        err_start = total_errors();
        wr_start  = mem_writes;
        wdat      = random_line();
        wsel      = $urandom;
        cpu_access(1'b1, line_addr(32'h200, 2), wsel, wdat, lat);
        for (int t = 1; t < 5; t++) begin
            cpu_access(1'b0, line_addr(32'h200 + t, 2), '1, '0, lat);
        end
        check_value(mem_writes == wr_start + 1,
                    $sformatf("%0d write-backs, expected 1", mem_writes - wr_start));
        check_value(last_wb_adr == line_addr(32'h200, 2),
                    $sformatf("write-back to %h, expected %h", last_wb_adr,
                              line_addr(32'h200, 2)));
        check_value(last_wb_dat == shadow_line(line_addr(32'h200, 2)),
                    "written back line differs from the merged line");
        cpu_access(1'b0, line_addr(32'h200, 2), '1, '0, lat);
        finish_test("4 eviction", err_start);

        err_start = total_errors();
        op_tag    = 32'h300;
        op_idx    = 0;
        for (int i = 0; i < RAND_OPS; i++) begin
            op_tag = 32'h300 + $urandom_range(5, 0);
            op_idx = $urandom_range(NUM_SETS - 1, 0);
            if ($urandom_range(1, 0) == 1) begin
                cpu_access(1'b1, line_addr(op_tag, op_idx), $urandom, random_line(), lat);
            end else begin
                cpu_access(1'b0, line_addr(op_tag, op_idx), '1, '0, lat);
            end
        end
        // a new tag must not evict the last line touched in its set
        a_mru = line_addr(op_tag, op_idx);
        cpu_access(1'b0, line_addr(32'h3ff, op_idx), '1, '0, lat);
        cyc_start = mem_cycles;
        cpu_access(1'b0, a_mru, '1, '0, lat);
        check_value(lat == 2 && mem_cycles == cyc_start,
                    $sformatf("line %h evicted although most recently used", a_mru));
        finish_test("5 random traffic", err_start);

        $display("checks: %0d, errors: %0d", checks + read_checks, total_errors());
        if (total_errors() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
hw/cache_pkg.sv
hw/way_array.sv
hw/plru_tree.sv
hw/cache_datapath.sv
hw/cache_control.sv
hw/l2_cache.sv
bench/mem_model.sv
bench/tb_l2_cache.sv

// ==== hw/cache_control.sv ====
/*
 * cache controller FSM
 * lookup, respond, write-back and fill sequencing
 * array write strobes, mux selects and LRU update
 */
`timescale 1ns/1ns

module cache_control
    import cache_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  wb_req_t                   cpu_req_i,
    output logic                      cpu_ack_o,
    input  logic                      mem_ack_i,
    output logic                      mem_cyc_o,
    output logic                      mem_stb_o,
    output logic                      mem_we_o,
    input  logic [NUM_WAYS-1:0]       hit_i,
    input  way_state_t [NUM_WAYS-1:0] state_i,
    input  way_idx_t                  victim_i,
    output logic [NUM_WAYS-1:0]       way_we_o,
    output logic [NUM_WAYS-1:0]       state_we_o,
    output way_state_t                state_o,
    output din_sel_t                  din_sel_o,
    output maddr_sel_t                maddr_sel_o,
    output way_idx_t                  victim_o,
    output logic                      lru_hit_o,
    output way_idx_t                  lru_way_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_RESPOND,
        S_WRITEBACK,
        S_FILL
    } fsm_t;

    fsm_t                fsm_q;
    fsm_t                fsm_d;
    way_idx_t            victim_q;
    way_idx_t            hit_way;
    logic                victim_dirty;
    logic [NUM_WAYS-1:0] victim_onehot;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_i[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign victim_dirty  = state_i[victim_i].valid && state_i[victim_i].dirty;
    assign victim_onehot = {{(NUM_WAYS-1){1'b0}}, 1'b1} << victim_q;
    assign victim_o      = victim_q;
    assign lru_way_o     = hit_way;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fsm_q    <= S_IDLE;
            victim_q <= '0;
        end else begin
            fsm_q <= fsm_d;
            // victim held through write-back and fill
            if (fsm_q == S_LOOKUP) begin
                victim_q <= victim_i;
            end
        end
    end

    always_comb begin
        fsm_d       = fsm_q;
        cpu_ack_o   = 1'b0;
        mem_cyc_o   = 1'b0;
        mem_stb_o   = 1'b0;
        mem_we_o    = 1'b0;
        way_we_o    = '0;
        state_we_o  = '0;
        state_o     = '0;
        din_sel_o   = DIN_CPU;
        maddr_sel_o = MADDR_REQ;
        lru_hit_o   = 1'b0;

        unique case (fsm_q)
            S_IDLE: begin
                if (cpu_req_i.cyc && cpu_req_i.stb) begin
                    fsm_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (|hit_i) begin
                    lru_hit_o = 1'b1;
                    if (cpu_req_i.we) begin
                        way_we_o   = hit_i;
                        state_we_o = hit_i;
                        state_o    = '{valid: 1'b1, dirty: 1'b1};
                    end
                    fsm_d = S_RESPOND;
                end else if (victim_dirty) begin
                    fsm_d = S_WRITEBACK;
                end else begin
                    fsm_d = S_FILL;
                end
            end
            S_RESPOND: begin
                cpu_ack_o = 1'b1;
                fsm_d     = S_IDLE;
            end
            S_WRITEBACK: begin
                mem_cyc_o   = 1'b1;
                mem_stb_o   = 1'b1;
                mem_we_o    = 1'b1;
                maddr_sel_o = MADDR_VICTIM;
                if (mem_ack_i) begin
                    fsm_d = S_FILL;
                end
            end
            S_FILL: begin
                mem_cyc_o = 1'b1;
                mem_stb_o = 1'b1;
                if (mem_ack_i) begin
                    way_we_o   = victim_onehot;
                    state_we_o = victim_onehot;
                    state_o    = '{valid: 1'b1, dirty: 1'b0};
                    din_sel_o  = DIN_MEM;
                    // the second lookup hits and finishes the access through the hit path
                    fsm_d      = S_LOOKUP;
                end
            end
            default: fsm_d = S_IDLE;
        endcase
    end

endmodule

// ==== hw/cache_datapath.sv ====
/*
 * tag, state and data arrays for four ways
 * tag compare and hit vector
 * byte merge and data-in mux, data-out muxes
 * memory address build for fill and write-back
 */
`timescale 1ns/1ns

module cache_datapath
    import cache_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  addr_t                     req_adr_i,
    input  line_t                     req_dat_i,
    input  be_t                       req_sel_i,
    input  line_t                     mem_dat_i,
    input  logic [NUM_WAYS-1:0]       way_we_i,
    input  logic [NUM_WAYS-1:0]       state_we_i,
    input  way_state_t                state_i,
    input  din_sel_t                  din_sel_i,
    input  maddr_sel_t                maddr_sel_i,
    input  way_idx_t                  victim_i,
    output logic [NUM_WAYS-1:0]       hit_o,
    output way_state_t [NUM_WAYS-1:0] state_o,
    output line_t                     rdata_o,
    output addr_t                     mem_adr_o,
    output line_t                     mem_dat_o
);

    addr_t              adr_q;
    line_t              dat_q;
    be_t                sel_q;
    logic [INDEX_W-1:0] set_idx;
    tag_t               req_tag;
    tag_t               tag_rd [NUM_WAYS];
    line_t              line_rd [NUM_WAYS];
    line_t              din_line;
    way_idx_t           hit_way;

    // CPU request registered every cycle
    always_ff @(posedge clk) begin
        adr_q <= req_adr_i;
        dat_q <= req_dat_i;
        sel_q <= req_sel_i;
    end

    assign set_idx = adr_q[OFFSET_W +: INDEX_W];
    assign req_tag = adr_q[OFFSET_W+INDEX_W +: TAG_W];

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        way_array #(
            .payload_t(tag_t)
        ) i_tag_array (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .we_i     (way_we_i[w]),
            .rindex_i (set_idx),
            .windex_i (set_idx),
            .wdata_i  (req_tag),
            .rdata_o  (tag_rd[w])
        );

        way_array #(
            .payload_t(way_state_t)
        ) i_state_array (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .we_i     (state_we_i[w]),
            .rindex_i (set_idx),
            .windex_i (set_idx),
            .wdata_i  (state_i),
            .rdata_o  (state_o[w])
        );

        way_array #(
            .payload_t(line_t)
        ) i_data_array (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .we_i     (way_we_i[w]),
            .rindex_i (set_idx),
            .windex_i (set_idx),
            .wdata_i  (din_line),
            .rdata_o  (line_rd[w])
        );

        assign hit_o[w] = state_o[w].valid && (tag_rd[w] == req_tag);
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_o[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    // cpu write merges into the hit line and a fill takes the memory line as is
    always_comb begin
        din_line = mem_dat_i;
        unique case (din_sel_i)
            DIN_CPU: begin
                din_line = line_rd[hit_way];
                for (int b = 0; b < $bits(be_t); b++) begin
                    if (sel_q[b]) begin
                        din_line[8*b +: 8] = dat_q[8*b +: 8];
                    end
                end
            end
            DIN_MEM: din_line = mem_dat_i;
        endcase
    end

    always_comb begin
        mem_adr_o = {adr_q[$bits(addr_t)-1:OFFSET_W], {OFFSET_W{1'b0}}};
        unique case (maddr_sel_i)
            MADDR_REQ:    mem_adr_o = {adr_q[$bits(addr_t)-1:OFFSET_W], {OFFSET_W{1'b0}}};
            MADDR_VICTIM: mem_adr_o = {tag_rd[victim_i], set_idx, {OFFSET_W{1'b0}}};
        endcase
    end

    assign rdata_o   = line_rd[hit_way];
    assign mem_dat_o = line_rd[victim_i];

endmodule

// ==== hw/cache_pkg.sv ====
/*
 * cache geometry localparams
 * address, line, byte enable and tag types
 * per-way state and pseudo-LRU types
 * wishbone request and response structs
 * datapath mux select enums
 */
package cache_pkg;

    localparam int OFFSET_W = 5;
    localparam int INDEX_W  = 3;
    localparam int TAG_W    = 32 - OFFSET_W - INDEX_W;
    localparam int NUM_WAYS = 4;
    localparam int NUM_SETS = 1 << INDEX_W;

    typedef logic [31:0]                     addr_t;
    typedef logic [8*(1 << OFFSET_W)-1:0]    line_t;
    typedef logic [(1 << OFFSET_W)-1:0]      be_t;
    typedef logic [TAG_W-1:0]                tag_t;
    typedef logic [2:0]                      plru_t;
    typedef logic [1:0]                      way_idx_t;

    typedef struct packed {
        logic valid;
        logic dirty;
    } way_state_t;

    // one whole line per wishbone classic transfer
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        be_t   sel;
        addr_t adr;
        line_t dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        line_t dat;
    } wb_rsp_t;

    // data array write source
    typedef enum logic {
        DIN_CPU,
        DIN_MEM
    } din_sel_t;

    // memory address source
    typedef enum logic {
        MADDR_REQ,
        MADDR_VICTIM
    } maddr_sel_t;

endpackage

// ==== hw/l2_cache.sv ====
/*
 * four-way write-back L2 cache top level
 * controller, datapath and pseudo-LRU
 * wishbone slave to CPU, wishbone master to memory
 */
`timescale 1ns/1ns

module l2_cache
    import cache_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n_i,
    input  wb_req_t cpu_req_i,
    output wb_rsp_t cpu_rsp_o,
    output wb_req_t mem_req_o,
    input  wb_rsp_t mem_rsp_i
);

    logic                      cpu_ack;
    logic                      mem_cyc;
    logic                      mem_stb;
    logic                      mem_we;
    logic [NUM_WAYS-1:0]       hit;
    way_state_t [NUM_WAYS-1:0] way_state;
    way_idx_t                  plru_victim;
    way_idx_t                  victim;
    logic [NUM_WAYS-1:0]       way_we;
    logic [NUM_WAYS-1:0]       state_we;
    way_state_t                state_wr;
    din_sel_t                  din_sel;
    maddr_sel_t                maddr_sel;
    logic                      lru_hit;
    way_idx_t                  lru_way;
    line_t                     rdata;
    addr_t                     mem_adr;
    line_t                     mem_dat;

    cache_control i_cache_control (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .cpu_req_i   (cpu_req_i),
        .cpu_ack_o   (cpu_ack),
        .mem_ack_i   (mem_rsp_i.ack),
        .mem_cyc_o   (mem_cyc),
        .mem_stb_o   (mem_stb),
        .mem_we_o    (mem_we),
        .hit_i       (hit),
        .state_i     (way_state),
        .victim_i    (plru_victim),
        .way_we_o    (way_we),
        .state_we_o  (state_we),
        .state_o     (state_wr),
        .din_sel_o   (din_sel),
        .maddr_sel_o (maddr_sel),
        .victim_o    (victim),
        .lru_hit_o   (lru_hit),
        .lru_way_o   (lru_way)
    );

    cache_datapath i_cache_datapath (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_adr_i   (cpu_req_i.adr),
        .req_dat_i   (cpu_req_i.dat),
        .req_sel_i   (cpu_req_i.sel),
        .mem_dat_i   (mem_rsp_i.dat),
        .way_we_i    (way_we),
        .state_we_i  (state_we),
        .state_i     (state_wr),
        .din_sel_i   (din_sel),
        .maddr_sel_i (maddr_sel),
        .victim_i    (victim),
        .hit_o       (hit),
        .state_o     (way_state),
        .rdata_o     (rdata),
        .mem_adr_o   (mem_adr),
        .mem_dat_o   (mem_dat)
    );

    // set index taken from the held CPU address
    plru_tree i_plru_tree (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .index_i   (cpu_req_i.adr[OFFSET_W +: INDEX_W]),
        .hit_i     (lru_hit),
        .hit_way_i (lru_way),
        .victim_o  (plru_victim)
    );

    assign cpu_rsp_o = '{ack: cpu_ack, dat: rdata};
    assign mem_req_o = '{cyc: mem_cyc, stb: mem_stb, we: mem_we, sel: '1,
                         adr: mem_adr, dat: mem_dat};

endmodule

// ==== hw/plru_tree.sv ====
/*
 * tree pseudo-LRU for four ways
 * three bits per set, updated on hit
 * victim way follows the tree path
 */
`timescale 1ns/1ns

module plru_tree
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic [INDEX_W-1:0] index_i,
    input  logic               hit_i,
    input  way_idx_t           hit_way_i,
    output way_idx_t           victim_o
);

    plru_t bits_rd;
    plru_t bits_wr;

    way_array #(
        .payload_t(plru_t)
    ) i_plru_array (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (hit_i),
        .rindex_i (index_i),
        .windex_i (index_i),
        .wdata_i  (bits_wr),
        .rdata_o  (bits_rd)
    );

    // bit 0 picks the pair, bit 1 inside ways 0/1, bit 2 inside ways 2/3
    // all bits point away from the way just used
    always_comb begin
        bits_wr    = bits_rd;
        bits_wr[0] = ~hit_way_i[1];
        if (hit_way_i[1]) begin
            bits_wr[2] = ~hit_way_i[0];
        end else begin
            bits_wr[1] = ~hit_way_i[0];
        end
    end

    always_comb begin
        if (bits_rd[0]) begin
            victim_o = {1'b1, bits_rd[2]};
        end else begin
            victim_o = {1'b0, bits_rd[1]};
        end
    end

endmodule

// ==== hw/way_array.sv ====
/*
 * per-set storage array
 * one write port, one combinational read port
 * payload chosen by type parameter
 */
`timescale 1ns/1ns

module way_array
    import cache_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               we_i,
    input  logic [INDEX_W-1:0] rindex_i,
    input  logic [INDEX_W-1:0] windex_i,
    input  payload_t           wdata_i,
    output payload_t           rdata_o
);

    payload_t mem_q [NUM_SETS];

    // cleared on reset so valid bits start low
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (we_i) begin
            mem_q[windex_i] <= wdata_i;
        end
    end

    assign rdata_o = mem_q[rindex_i];

endmodule
